//--- logic/arb_settings.svh
`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// number of requesting ports
`define ARB_N 4

// packet data width in bits
`define ARB_DW 32

`endif

//--- logic/arb_pkg.sv
`include "arb_settings.svh"

package arb_pkg;

   // one bit per requesting port
   typedef logic [`ARB_N-1:0] arb_vec_t;

   // arbitration policy, rsvd falls back to fixed priority
   typedef enum logic [1:0] {
      mode_priority = 2'd0,
      mode_rr       = 2'd1,
      mode_reserve  = 2'd2,
      mode_rsvd     = 2'd3
   } arb_mode_t;

   // one beat of a request packet
   typedef struct packed {
      logic [1:0]        cmd;
      logic [15:0]       addr;
      logic [`ARB_DW-1:0] data;
      logic              last;  // final beat of the packet
   } arb_pkt_t;

   typedef struct packed {
      logic     busy;       // burst lock held
      arb_vec_t owner;      // one-hot locked port
      logic     collision;  // someone was refused this cycle
   } arb_status_t;

endpackage

//--- logic/arb_priority.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module arb_priority
   import arb_pkg::*;
   (
   input  arb_vec_t requests,
   output arb_vec_t grants
   );

   // lowest index wins, zero when nobody asks
   always_comb
   begin
      logic found;
      found  = 1'b0;
      grants = '0;
      for (int i = 0; i < `ARB_N; i++)
      begin
         if (requests[i] && !found)
         begin
            grants[i] = 1'b1;  // first hit from the bottom
            found     = 1'b1;
         end
      end
   end

endmodule

//--- logic/arb_thermometer.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module arb_thermometer
   import arb_pkg::*;
   (
   input            clk,
   input            nreset,
   input            step,   // one collision seen
   output arb_vec_t therm   // 1 = input blocked
   );

   arb_vec_t therm_next;

   // fills from bit 0 upward, top bit never set
   generate
      if (`ARB_N > 1)
      begin : g_multi
         always_comb
         begin
            if (&therm[`ARB_N-2:0])
               therm_next = '0;  // all low ports blocked, wrap
            else
               therm_next = {therm[`ARB_N-2:0], 1'b1};
         end
      end
      else
      begin : g_single
         // nothing to reserve with a single port
         assign therm_next = '0;
      end
   endgenerate

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         therm <= '0;
      else if (step)
         therm <= therm_next;
   end

endmodule

//--- logic/arb_core.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module arb_core
   import arb_pkg::*;
   (
   input             clk,
   input             nreset,
   input  arb_mode_t mode,
   input  arb_vec_t  mask,      // 1 = port disabled
   input  arb_vec_t  requests,
   input             arb_en,    // from burst controller
   output arb_vec_t  grants,
   output logic      collision
   );

   arb_vec_t therm;
   arb_vec_t therm_eff;   // thermometer only bites in reserve mode
   arb_vec_t spec_req;    // requests left after all masking
   arb_vec_t rr_mask;     // ports at or above the rr pointer
   arb_vec_t rr_next;
   arb_vec_t hi_grants;
   arb_vec_t lo_grants;
   logic     reserve_on;

   assign reserve_on = (mode == mode_reserve);
   assign therm_eff  = reserve_on ? therm : '0;

   assign spec_req = requests & ~mask & ~therm_eff & {`ARB_N{arb_en}};

   // upper half of the rr search, from pointer upward
   arb_priority u_prio_hi (
      .requests (spec_req & rr_mask),
      .grants   (hi_grants)
   );

   // plain priority, also the rr wrap-around search
   arb_priority u_prio_lo (
      .requests (spec_req),
      .grants   (lo_grants)
   );

   always_comb
   begin
      case (mode)
         mode_rr:
            grants = (|hi_grants) ? hi_grants : lo_grants;
         default:
            grants = lo_grants;  // priority, reserve and rsvd
      endcase
   end

   // refused raw request while arbitration was live
   assign collision = arb_en & (|(requests & ~grants));

   arb_thermometer u_therm (
      .clk    (clk),
      .nreset (nreset),
      .step   (collision & reserve_on),
      .therm  (therm)
   );

   // ports strictly above the winner, empty after top port wins
   always_comb
   begin
      rr_next = '0;
      for (int i = 1; i < `ARB_N; i++)
         rr_next[i] = rr_next[i-1] | grants[i-1];
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rr_mask <= '1;  // pointer at port 0
      else if ((mode == mode_rr) && (|grants))
         rr_mask <= rr_next;
   end

endmodule

//--- logic/arb_burst_ctrl.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module arb_burst_ctrl
   import arb_pkg::*;
   (
   input               clk,
   input               nreset,
   input  arb_vec_t    requests,
   input  arb_vec_t    grants_raw,   // from the core
   input  arb_vec_t    pkt_last,     // last flag per port
   input               out_ready,
   input               collision,
   output logic        arb_en,
   output arb_vec_t    final_grant,
   output arb_status_t status
   );

   typedef enum logic {
      st_idle  = 1'b0,
      st_burst = 1'b1
   } burst_state_t;

   burst_state_t state, state_next;
   arb_vec_t     owner;        // locked port, one-hot
   logic         fire;         // a beat moves this cycle
   logic         last_fire;    // and it is the final one

   always_comb
   begin
      if (state == st_burst)
      begin
         arb_en      = 1'b0;  // core sits out the burst
         final_grant = owner & requests & {`ARB_N{out_ready}};
      end
      else
      begin
         arb_en      = out_ready;
         final_grant = grants_raw;  // already zero when not enabled
      end
   end

   assign fire      = |final_grant;
   assign last_fire = |(final_grant & pkt_last);

   always_comb
   begin
      state_next = state;
      if (state == st_idle && fire && !last_fire)
         state_next = st_burst;   // multi-beat packet started
      else if (state == st_burst && last_fire)
         state_next = st_idle;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state <= st_idle;
         owner <= '0;
      end
      else
      begin
         state <= state_next;
         if (state == st_idle && state_next == st_burst)
            owner <= final_grant;  // latch the winner
         else if (state_next == st_idle)
            owner <= '0;
      end
   end

   assign status.busy      = (state == st_burst);
   assign status.owner     = owner;
   assign status.collision = collision;

endmodule

//--- logic/arb_out_mux.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module arb_out_mux
   import arb_pkg::*;
   #(
   parameter type payload_t = arb_pkt_t
   )
   (
   input            clk,
   input            nreset,
   input  arb_vec_t sel,                   // one-hot grant
   input  payload_t payloads [`ARB_N],
   output logic     out_valid,
   output payload_t out_data
   );

   localparam int PW = $bits(payload_t);

   logic [PW-1:0] sel_bits;   // and-or result
   logic          sel_any;

   // and-or select, relies on sel being one-hot
   always_comb
   begin
      sel_bits = '0;
      for (int i = 0; i < `ARB_N; i++)
         sel_bits = sel_bits | (payloads[i] & {PW{sel[i]}});
   end

   assign sel_any = |sel;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         out_valid <= 1'b0;
      else
         out_valid <= sel_any;  // drops a cycle after a gap
   end

   // payload holds between beats
   always_ff @(posedge clk)
   begin
      if (sel_any)
         out_data <= payload_t'(sel_bits);
   end

endmodule

//--- logic/arb_switch_top.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module arb_switch_top
   import arb_pkg::*;
   (
   input               clk,
   input               nreset,
   input  arb_mode_t   mode,
   input  arb_vec_t    mask,
   input  arb_vec_t    in_req,
   input  arb_pkt_t    in_pkt [`ARB_N],
   input               out_ready,
   output arb_vec_t    in_grant,
   output logic        out_valid,
   output arb_pkt_t    out_pkt,
   output arb_status_t status
   );

   arb_vec_t grants_raw;
   arb_vec_t pkt_last;     // last flags gathered per port
   logic     arb_en;
   logic     collision;

   always_comb
   begin
      for (int i = 0; i < `ARB_N; i++)
         pkt_last[i] = in_pkt[i].last;
   end

   arb_core u_core (
      .clk       (clk),
      .nreset    (nreset),
      .mode      (mode),
      .mask      (mask),
      .requests  (in_req),
      .arb_en    (arb_en),
      .grants    (grants_raw),
      .collision (collision)
   );

   arb_burst_ctrl u_burst (
      .clk         (clk),
      .nreset      (nreset),
      .requests    (in_req),
      .grants_raw  (grants_raw),
      .pkt_last    (pkt_last),
      .out_ready   (out_ready),
      .collision   (collision),
      .arb_en      (arb_en),
      .final_grant (in_grant),   // to ports and mux select
      .status      (status)
   );

   arb_out_mux #(.payload_t(arb_pkt_t)) u_mux (
      .clk       (clk),
      .nreset    (nreset),
      .sel       (in_grant),
      .payloads  (in_pkt),
      .out_valid (out_valid),
      .out_data  (out_pkt)
   );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
   #(
   parameter real PERIOD       = 8.0,
   parameter int  RESET_CYCLES = 2
   )
   (
   output logic clk,
   output logic nreset
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

   // reset low for a couple of edges, released off the edge
   initial
   begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 nreset = 1'b1;
   end

endmodule

//--- sim/tb_arb_switch.sv
`timescale 1ns/10ps
`include "arb_settings.svh"

module tb_arb_switch
   import arb_pkg::*;
   ;

   localparam int TEST_CYCLES = 200;
   localparam int N_TESTS     = 8;
   localparam int DRAIN_MAX   = 80;   // 4 ports x 4 beats with ready gaps, generous
   localparam int CYCLE_LIMIT = N_TESTS * (TEST_CYCLES + DRAIN_MAX) + 100;

   logic        clk;
   logic        nreset;
   arb_mode_t   mode;
   arb_vec_t    mask;
   arb_vec_t    req;
   arb_pkt_t    pkt [`ARB_N];
   logic        ready;
   arb_vec_t    in_grant;
   logic        out_valid;
   arb_pkt_t    out_pkt;
   arb_status_t status;

   logic [31:0] lfsr = 32'he8f4;
   int          left [`ARB_N];   // beats still to send per port
   int          seq [`ARB_N];
   logic        cfg_issue, cfg_steady, cfg_gaps;
   int          cfg_len;
   string       test_name = "reset";
   int          errors, tests_run, cycles, beats_in, beats_out;

   // reference model state
   int          m_ptr, m_tcnt, m_owner;
   logic        m_busy;
   arb_vec_t    exp_grant, owner_vec;
   logic        exp_en, exp_coll, exp_valid;
   int          exp_win;
   arb_pkt_t    exp_pkt;

   tb_clock #(.PERIOD(8.0), .RESET_CYCLES(2)) u_clock (.clk(clk), .nreset(nreset));

   arb_switch_top dut (
      .clk       (clk),
      .nreset    (nreset),
      .mode      (mode),
      .mask      (mask),
      .in_req    (req),
      .in_pkt    (pkt),
      .out_ready (ready),
      .in_grant  (in_grant),
      .out_valid (out_valid),
      .out_pkt   (out_pkt),
      .status    (status)
   );

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};   // one step per bit
      end
   endtask

   // blocked ports in reserve mode, c low bits set
   function automatic arb_vec_t therm_bits(input int c);
      arb_vec_t t;
      t = '0;
      for (int i = 0; i < c; i++)
         t[i] = 1'b1;
      return t;
   endfunction

   function automatic int lowest_from(input arb_vec_t v, input int start);
      int w;
      w = -1;
      for (int i = `ARB_N - 1; i >= start; i--)
         if (v[i])
            w = i;   // keeps the lowest hit
      return w;
   endfunction

   always_comb
   begin
      arb_vec_t elig;
      arb_vec_t tmask;
      exp_en    = ready && !m_busy;
      tmask     = (mode == mode_reserve) ? therm_bits(m_tcnt) : '0;
      elig      = req & ~mask & ~tmask;
      exp_grant = '0;
      owner_vec = '0;
      owner_vec[m_owner] = m_busy;
      exp_win   = -1;
      if (m_busy)
      begin
         if (ready && req[m_owner])
            exp_win = m_owner;   // lock holds, mask and policy ignored
      end
      else if (exp_en)
      begin
         if (mode == mode_rr)
            exp_win = lowest_from(elig, m_ptr);
         if (exp_win < 0)
            exp_win = lowest_from(elig, 0);   // wrap, or plain priority
      end
      if (exp_win >= 0)
         exp_grant[exp_win] = 1'b1;
      exp_coll = exp_en && ((req & ~exp_grant) != '0);
   end

   always @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         m_ptr     <= 0;
         m_tcnt    <= 0;
         m_busy    <= 1'b0;
         m_owner   <= 0;
         exp_valid <= 1'b0;
      end
      else
      begin
         exp_valid <= (exp_win >= 0);
         if (exp_win >= 0)
         begin
            exp_pkt <= pkt[exp_win];
            if (!m_busy && !pkt[exp_win].last)
            begin
               m_busy  <= 1'b1;   // multi-beat packet starts
               m_owner <= exp_win;
            end
            else if (m_busy && pkt[exp_win].last)
               m_busy <= 1'b0;
            if (!m_busy && mode == mode_rr)
               m_ptr <= (exp_win + 1) % `ARB_N;
         end
         if (exp_coll && mode == mode_reserve)
            m_tcnt <= (m_tcnt == `ARB_N - 1) ? 0 : m_tcnt + 1;
      end
   end

   a_onehot: assert property (@(posedge clk) disable iff (!nreset) $onehot0(in_grant))
      else begin
         $display("%s: grant is not one-hot, got %b", test_name, $sampled(in_grant));
         errors++;
      end
   a_masked: assert property (@(posedge clk) disable iff (!nreset)
                              (in_grant & ~(req & ~mask)) == '0)
      else begin
         $display("%s: grant %b went to a port that is masked or not requesting",
                  test_name, $sampled(in_grant));
         errors++;
      end
   a_ready: assert property (@(posedge clk) disable iff (!nreset) ready || in_grant == '0)
      else begin
         $display("%s: grant given while the consumer was not ready", test_name);
         errors++;
      end
   a_grant: assert property (@(posedge clk) disable iff (!nreset) in_grant == exp_grant)
      else begin
         $display("[ERROR] %s: in_grant expected %b actual %b", test_name,
                  $sampled(exp_grant), $sampled(in_grant));
         errors++;
      end
   a_lock: assert property (@(posedge clk) disable iff (!nreset)
                            !m_busy || (in_grant & ~owner_vec) == '0)
      else begin
         $display("%s: grant left the burst owner %b mid-packet", test_name,
                  $sampled(owner_vec));
         errors++;
      end
   a_busy: assert property (@(posedge clk) disable iff (!nreset) status.busy == m_busy)
      else begin
         $display("[ERROR] %s: status.busy expected %b actual %b", test_name,
                  $sampled(m_busy), $sampled(status.busy));
         errors++;
      end
   a_owner: assert property (@(posedge clk) disable iff (!nreset) status.owner == owner_vec)
      else begin
         $display("[ERROR] %s: status.owner expected %b actual %b", test_name,
                  $sampled(owner_vec), $sampled(status.owner));
         errors++;
      end
   a_coll: assert property (@(posedge clk) disable iff (!nreset)
                            status.collision == exp_coll)
      else begin
         $display("[ERROR] %s: status.collision expected %b actual %b", test_name,
                  $sampled(exp_coll), $sampled(status.collision));
         errors++;
      end
   a_valid: assert property (@(posedge clk) disable iff (!nreset) out_valid == exp_valid)
      else begin
         $display("[ERROR] %s: out_valid expected %b actual %b", test_name,
                  $sampled(exp_valid), $sampled(out_valid));
         errors++;
      end
   a_data: assert property (@(posedge clk) disable iff (!nreset)
                            !exp_valid || out_pkt == exp_pkt)
      else begin
         $display("[ERROR] %s: out_pkt expected %h actual %h", test_name,
                  $sampled(exp_pkt), $sampled(out_pkt));
         errors++;
      end

   always @(posedge clk)
   begin
      cycles++;
      if (nreset && exp_win >= 0)
         beats_in++;
      if (nreset && out_valid)
         beats_out++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   task automatic make_beat(input int i);
      logic [31:0] r;
      take_bits(2, r);
      pkt[i].cmd = r[1:0];
      take_bits(`ARB_DW, r);
      pkt[i].data = r;
      pkt[i].addr = 16'(i * 4096 + seq[i]);   // port in the top nibble
      pkt[i].last = (left[i] == 1);
      seq[i]++;
   endtask

   task automatic start_packet(input int i);
      logic [31:0] r;
      take_bits(2, r);
      left[i] = (cfg_len > 1) ? 1 + int'(r) % cfg_len : 1;
      req[i]  = 1'b1;
      make_beat(i);
   endtask

   // one clock, grant seen mid-cycle, inputs moved just after the edge
   task automatic run_cycle();
      arb_vec_t    g;
      logic [31:0] r;
      @(negedge clk);
      g = in_grant;
      @(posedge clk);
      #1;
      for (int i = 0; i < `ARB_N; i++)
      begin
         if (g[i])
         begin
            if (pkt[i].last)
               req[i] = 1'b0;   // packet done
            else
            begin
               left[i]--;
               make_beat(i);
            end
         end
         if (!req[i] && cfg_issue)
         begin
            take_bits(1, r);
            if (cfg_steady || r[0])
               start_packet(i);
         end
      end
      if (cfg_gaps)
      begin
         take_bits(2, r);
         ready = (r[1:0] != 2'b00);   // roughly one gap in four
      end
      else
         ready = 1'b1;
   endtask

   task automatic run_test(input string name, input arb_mode_t m, input arb_vec_t mk,
                           input logic steady, input int len, input logic gaps);
      int granted_before;
      granted_before = beats_in;
      test_name  = name;
      mode       = m;
      mask       = mk;
      cfg_steady = steady;
      cfg_len    = len;
      cfg_gaps   = gaps;
      cfg_issue  = 1'b1;
      repeat (TEST_CYCLES) run_cycle();
      cfg_issue = 1'b0;
      while ((req & ~mask) != '0)
         run_cycle();
      req   = '0;      // masked ports give up
      ready = 1'b1;
      run_cycle();     // last beat reaches the output
      tests_run++;
      $display("test %-16s done, %0d beats granted, %0d errors so far", name,
               beats_in - granted_before, errors);
   endtask

   initial
   begin
      mode      = mode_priority;
      mask      = '0;
      req       = '0;
      ready     = 1'b0;
      cfg_issue = 1'b0;
      cfg_len   = 1;
      for (int i = 0; i < `ARB_N; i++)
      begin
         pkt[i]  = '0;
         left[i] = 0;
         seq[i]  = 0;
      end
      @(posedge nreset);
      @(posedge clk);
      #1;
      run_test("priority_single", mode_priority, 4'b0000, 1'b0, 1, 1'b0);
      run_test("priority_masked", mode_priority, 4'b0010, 1'b0, 1, 1'b1);
      run_test("reserved_mode", mode_rsvd, 4'b0000, 1'b0, 1, 1'b0);
      run_test("rr_steady", mode_rr, 4'b0000, 1'b1, 1, 1'b0);
      run_test("rr_masked", mode_rr, 4'b0100, 1'b1, 1, 1'b0);
      run_test("reserve_therm", mode_reserve, 4'b0000, 1'b0, 1, 1'b0);
      run_test("burst_lock", mode_priority, 4'b0000, 1'b0, 4, 1'b0);
      run_test("ready_gaps", mode_rr, 4'b1000, 1'b0, 4, 1'b1);
      run_cycle();
      assert (beats_out == beats_in)
      else begin
         $display("[ERROR] beat count: expected %0d actual %0d", beats_in, beats_out);
         errors++;
      end
      $display("tests run %0d, beats granted %0d, beats out %0d, errors %0d",
               tests_run, beats_in, beats_out, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- build.f
+incdir+logic
logic/arb_pkg.sv
logic/arb_priority.sv
logic/arb_thermometer.sv
logic/arb_core.sv
logic/arb_burst_ctrl.sv
logic/arb_out_mux.sv
logic/arb_switch_top.sv
sim/tb_clock.sv
sim/tb_arb_switch.sv

//--- run_sim.sh
#!/bin/sh
# build the switch testbench with verilator, run it, look for the pass line
verilator --binary --timing --assert -f build.f --top-module tb_arb_switch \
   -o tb_arb_switch \
   && ./obj_dir/tb_arb_switch | tee /dev/stderr | grep -q "Test passed" \
   && echo "simulation ok" \
   || { echo "simulation FAILED"; exit 1; }
